/* hw/bcm_timer.sv */
// ====================
// binary-weighted on-time for one bitplane
// ====================
module bcm_timer #(
    parameter int BASE_TICKS = 4
) (
    input  logic               clk_root,
    input  logic               rst_n,
    input  logic               start,
    input  matrix_pkg::plane_t plane,
    output logic               done
);

    import matrix_pkg::*;

    localparam int MAX_TICKS = BASE_TICKS << (COLOR_DEPTH - 1);
    localparam int CNT_W     = $clog2(MAX_TICKS + 1);

    logic [CNT_W-1:0] cnt_q;   // zero when idle

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (start) begin
            cnt_q <= CNT_W'(BASE_TICKS) << plane;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign done = (cnt_q == CNT_W'(1));   // last enabled cycle

endmodule

/* hw/cmd_decoder.sv */
// ====================
// command decoder: pixel writes and mask registers
// ====================
module cmd_decoder (
    input  logic                                clk_root,
    input  logic                                rst_n,
    input  logic [7:0]                          rx_byte,
    input  logic                                rx_valid,
    output ctrl_pkg::fb_write_t                 fb_wr,
    output logic [matrix_pkg::COLOR_DEPTH-1:0] brightness_en,
    output matrix_pkg::rgb_bits_t               rgb_en
);

    import matrix_pkg::*;
    import ctrl_pkg::*;

    dec_state_t state;
    cmd_op_t    opcode;
    logic       wr_q;
    logic       bottom_q;
    fb_addr_t   addr_q;
    pixel_t     pix_q;

    assign opcode = cmd_op_t'(rx_byte);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state         <= DEC_IDLE;
            wr_q          <= 1'b0;
            brightness_en <= '1;
            rgb_en        <= '1;
        end else begin
            wr_q <= 1'b0;
            if (rx_valid) begin
                case (state)
                    DEC_IDLE: begin
                        case (opcode)
                            WRITE_PIXEL:    state <= DEC_PIX_ADDR;
                            SET_BRIGHTNESS: state <= DEC_BRIGHT;
                            SET_RGB:        state <= DEC_RGB;
                            default:        state <= DEC_IDLE;   // unknown, ignore
                        endcase
                    end
                    DEC_PIX_ADDR: state <= DEC_PIX_DATA;
                    DEC_PIX_DATA: begin
                        wr_q  <= 1'b1;
                        state <= DEC_IDLE;
                    end
                    DEC_BRIGHT: begin
                        brightness_en <= rx_byte[COLOR_DEPTH-1:0];
                        state         <= DEC_IDLE;
                    end
                    DEC_RGB: begin
                        rgb_en <= rgb_bits_t'(rx_byte[2:0]);
                        state  <= DEC_IDLE;
                    end
                    default: state <= DEC_IDLE;
                endcase
            end
        end
    end

    // address byte: bit 6 half, 5..4 row, 3..0 column
    always_ff @(posedge clk_root) begin
        if (rx_valid && state == DEC_PIX_ADDR) begin
            bottom_q <= rx_byte[6];
            addr_q   <= '{row: row_addr_t'(rx_byte[5:4]), col: col_addr_t'(rx_byte[3:0])};
        end
        if (rx_valid && state == DEC_PIX_DATA) begin
            pix_q <= pixel_t'(rx_byte[5:0]);
        end
    end

    assign fb_wr = '{wr: wr_q, bottom: bottom_q, addr: addr_q, pixel: pix_q};

endmodule

/* hw/ctrl_pkg.sv */
// ====================
// command opcodes and decoder types
// ====================
package ctrl_pkg;

    typedef enum logic [7:0] {
        WRITE_PIXEL    = 8'h01,
        SET_BRIGHTNESS = 8'h02,
        SET_RGB        = 8'h03
    } cmd_op_t;

    typedef enum logic [2:0] {
        DEC_IDLE,
        DEC_PIX_ADDR,   // waiting for half/row/col byte
        DEC_PIX_DATA,
        DEC_BRIGHT,
        DEC_RGB
    } dec_state_t;

    typedef struct packed {
        logic                 wr;
        logic                 bottom;   // 1 selects lower half
        matrix_pkg::fb_addr_t addr;
        matrix_pkg::pixel_t   pixel;
    } fb_write_t;

endpackage

/* hw/framebuffer.sv */
// ====================
// two-bank pixel store, top and bottom half
// ====================
module framebuffer (
    input  logic                 clk_root,
    input  logic                 rst_n,
    input  ctrl_pkg::fb_write_t  fb_wr,
    input  matrix_pkg::fb_addr_t rd_addr,
    input  logic                 rd_strobe,
    output matrix_pkg::pixel_t   pix_top,
    output matrix_pkg::pixel_t   pix_bottom
);

    import matrix_pkg::*;

    localparam int DEPTH = NUM_ROW_ADDR * NUM_COLS;

    pixel_t mem [2][DEPTH];   // [0] top, [1] bottom

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[0][i] <= '0;
                mem[1][i] <= '0;
            end
        end else if (fb_wr.wr) begin
            mem[fb_wr.bottom][fb_wr.addr] <= fb_wr.pixel;
        end
    end

    // both halves read at the same address
    always_ff @(posedge clk_root) begin
        if (rd_strobe) begin
            pix_top    <= mem[0][rd_addr];
            pix_bottom <= mem[1][rd_addr];
        end
    end

endmodule

/* hw/led_matrix_top.sv */
// ====================
// led matrix driver top
// uart commands in, hub75 style panel signals out
// ====================
module led_matrix_top #(
    parameter int TICKS_PER_BIT = 8,
    parameter int BASE_TICKS    = 4
) (
    input  logic                   clk_root,
    input  logic                   rst_n,
    input  logic                   serial_in,
    output matrix_pkg::panel_out_t panel
);

    import matrix_pkg::*;
    import ctrl_pkg::*;

    logic [7:0]             rx_byte;
    logic                   rx_valid;
    fb_write_t              fb_wr;
    logic [COLOR_DEPTH-1:0] brightness_en;
    rgb_bits_t              rgb_en;
    fb_addr_t               rd_addr;
    logic                   rd_strobe;
    plane_t                 plane;
    rgb_bits_t              rgb_top;
    rgb_bits_t              rgb_bottom;

    uart_rx #(
        .TICKS_PER_BIT (TICKS_PER_BIT)
    ) uart_rx_i (
        .clk_root  (clk_root),
        .rst_n     (rst_n),
        .serial_in (serial_in),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    cmd_decoder cmd_decoder_i (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .fb_wr         (fb_wr),
        .brightness_en (brightness_en),
        .rgb_en        (rgb_en)
    );

    pixel_fetch pixel_fetch_i (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .fb_wr         (fb_wr),
        .rd_addr       (rd_addr),
        .rd_strobe     (rd_strobe),
        .plane         (plane),
        .brightness_en (brightness_en),
        .rgb_en        (rgb_en),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom)
    );

    scan_fsm #(
        .BASE_TICKS (BASE_TICKS)
    ) scan_fsm_i (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .rd_addr    (rd_addr),
        .rd_strobe  (rd_strobe),
        .plane      (plane),
        .panel      (panel)
    );

endmodule

/* hw/matrix_pkg.sv */
// ====================
// matrix geometry and pixel types
// shared by the store and scan paths
// ====================
package matrix_pkg;

    localparam int NUM_COLS     = 16;
    localparam int NUM_ROW_ADDR = 4;   // per half
    localparam int COLOR_DEPTH  = 2;   // bits per channel, also plane count

    typedef logic [3:0] col_addr_t;
    typedef logic [1:0] row_addr_t;
    typedef logic [0:0] plane_t;

    typedef struct packed {
        logic [COLOR_DEPTH-1:0] red;
        logic [COLOR_DEPTH-1:0] green;
        logic [COLOR_DEPTH-1:0] blue;
    } pixel_t;

    // one plane of one pixel
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_bits_t;

    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
    } fb_addr_t;

    typedef struct packed {
        rgb_bits_t rgb_top;
        rgb_bits_t rgb_bottom;
        row_addr_t row_addr;
        logic      clk_pixel;
        logic      row_latch;
        logic      output_enable;
    } panel_out_t;

endpackage

/* hw/pixel_fetch.sv */
// ====================
// column pair read, reduced to masked plane bits
// ====================
module pixel_fetch (
    input  logic                                clk_root,
    input  logic                                rst_n,
    input  ctrl_pkg::fb_write_t                 fb_wr,
    input  matrix_pkg::fb_addr_t                rd_addr,
    input  logic                                rd_strobe,
    input  matrix_pkg::plane_t                  plane,
    input  logic [matrix_pkg::COLOR_DEPTH-1:0] brightness_en,
    input  matrix_pkg::rgb_bits_t               rgb_en,
    output matrix_pkg::rgb_bits_t               rgb_top,
    output matrix_pkg::rgb_bits_t               rgb_bottom
);

    import matrix_pkg::*;

    pixel_t    pix_top;
    pixel_t    pix_bottom;
    rgb_bits_t chan_en;

    function automatic rgb_bits_t plane_bits(input pixel_t pix, input plane_t sel,
                                             input rgb_bits_t en);
        rgb_bits_t bits;
        bits.red   = pix.red[sel] & en.red;
        bits.green = pix.green[sel] & en.green;
        bits.blue  = pix.blue[sel] & en.blue;
        return bits;
    endfunction

    framebuffer fb_i (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .fb_wr      (fb_wr),
        .rd_addr    (rd_addr),
        .rd_strobe  (rd_strobe),
        .pix_top    (pix_top),
        .pix_bottom (pix_bottom)
    );

    // a disabled plane blanks every channel
    assign chan_en    = rgb_en & {3{brightness_en[plane]}};
    assign rgb_top    = plane_bits(pix_top, plane, chan_en);
    assign rgb_bottom = plane_bits(pix_bottom, plane, chan_en);

endmodule

/* hw/scan_fsm.sv */
// ====================
// panel scan: shift, latch and display per row and plane
// ====================
module scan_fsm #(
    parameter int BASE_TICKS = 4
) (
    input  logic                  clk_root,
    input  logic                  rst_n,
    input  matrix_pkg::rgb_bits_t rgb_top,
    input  matrix_pkg::rgb_bits_t rgb_bottom,
    output matrix_pkg::fb_addr_t  rd_addr,
    output logic                  rd_strobe,
    output matrix_pkg::plane_t    plane,
    output matrix_pkg::panel_out_t panel
);

    import matrix_pkg::*;

    typedef enum logic [2:0] {S_FETCH, S_SHIFT, S_LATCH, S_ENABLE, S_DISPLAY} scan_state_t;

    localparam col_addr_t LAST_COL   = col_addr_t'(NUM_COLS - 1);
    localparam plane_t    LAST_PLANE = plane_t'(COLOR_DEPTH - 1);

    scan_state_t state;
    logic        phase;   // 0 sets data, 1 raises clk_pixel
    col_addr_t   col_q;
    row_addr_t   row_q;
    plane_t      plane_q;
    logic        timer_done;

    assign plane = plane_q;

    // next column is read while the current one is clocked out
    assign rd_strobe = (state == S_FETCH) || (state == S_SHIFT && !phase && col_q != LAST_COL);
    assign rd_addr   = '{row: row_q, col: (state == S_FETCH) ? col_addr_t'(0) : col_q + 1'b1};

    bcm_timer #(
        .BASE_TICKS (BASE_TICKS)
    ) timer_i (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .start    (state == S_ENABLE),
        .plane    (plane_q),
        .done     (timer_done)
    );

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_FETCH;
            phase   <= 1'b0;
            col_q   <= '0;
            row_q   <= '0;
            plane_q <= '0;
            panel   <= '0;
        end else begin
            case (state)
                S_FETCH: begin
                    col_q <= '0;
                    phase <= 1'b0;
                    state <= S_SHIFT;
                end
                S_SHIFT: begin
                    phase <= ~phase;
                    if (!phase) begin
                        panel.rgb_top    <= rgb_top;
                        panel.rgb_bottom <= rgb_bottom;
                        panel.clk_pixel  <= 1'b0;
                    end else begin
                        panel.clk_pixel <= 1'b1;
                        if (col_q == LAST_COL) begin
                            state <= S_LATCH;
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end
                end
                S_LATCH: begin
                    panel.clk_pixel <= 1'b0;
                    panel.row_latch <= 1'b1;
                    panel.row_addr  <= row_q;   // row switches with the latch
                    state           <= S_ENABLE;
                end
                S_ENABLE: begin
                    panel.row_latch     <= 1'b0;
                    panel.output_enable <= 1'b1;
                    state               <= S_DISPLAY;
                end
                S_DISPLAY: begin
                    if (timer_done) begin
                        panel.output_enable <= 1'b0;
                        state               <= S_FETCH;
                        if (plane_q == LAST_PLANE) begin
                            plane_q <= '0;
                            row_q   <= row_q + 1'b1;   // wraps after 3
                        end else begin
                            plane_q <= plane_q + 1'b1;
                        end
                    end
                end
                default: state <= S_FETCH;
            endcase
        end
    end

endmodule

/* hw/uart_rx.sv */
// ====================
// 8N1 uart receiver, one strobe per good byte
// ====================
module uart_rx #(
    parameter int TICKS_PER_BIT = 8
) (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       serial_in,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int CNT_W = $clog2(TICKS_PER_BIT) + 1;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic [1:0]       sync_q;
    logic [CNT_W-1:0] tick_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic             line;
    logic             mid_bit;

    assign line    = sync_q[1];
    assign mid_bit = (tick_cnt == '0);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b11;   // line idles high
        end else begin
            sync_q <= {sync_q[0], serial_in};
        end
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (state != RX_IDLE && !mid_bit) begin
                tick_cnt <= tick_cnt - 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    if (!line) begin
                        state    <= RX_START;
                        tick_cnt <= CNT_W'(TICKS_PER_BIT / 2 - 1);   // half bit to centre
                    end
                end
                RX_START: begin
                    if (mid_bit) begin
                        state    <= line ? RX_IDLE : RX_DATA;   // glitch check
                        tick_cnt <= CNT_W'(TICKS_PER_BIT - 1);
                        bit_idx  <= '0;
                    end
                end
                RX_DATA: begin
                    if (mid_bit) begin
                        tick_cnt <= CNT_W'(TICKS_PER_BIT - 1);
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (mid_bit) begin
                        rx_valid <= line;   // bad stop bit drops the frame
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_root) begin
        if (state == RX_DATA && mid_bit) begin
            shift_q <= {line, shift_q[7:1]};
        end
        if (state == RX_STOP && mid_bit && line) begin
            rx_byte <= shift_q;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the led matrix testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -f sim.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

/* sim.f */
hw/matrix_pkg.sv
hw/ctrl_pkg.sv
hw/uart_rx.sv
hw/cmd_decoder.sv
hw/framebuffer.sv
hw/bcm_timer.sv
hw/pixel_fetch.sv
hw/scan_fsm.sv
hw/led_matrix_top.sv
verif/clk_rst_gen.sv
verif/scan_checker.sv
verif/tb_top.sv

/* verif/clk_rst_gen.sv */
// ====================
// testbench clock and reset source
// ====================
module clk_rst_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_root,
    output logic rst_n
);

    initial begin
        clk_root = 1'b0;
        forever #(PERIOD / 2) clk_root = ~clk_root;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_root);
        #1 rst_n = 1'b1;   // released just after the edge
    end

endmodule

/* verif/scan_checker.sv */
// ====================
// panel control checks, bound into the scan FSM
// ====================
module scan_checker (
    input logic                   clk_root,
    input logic                   rst_n,
    input matrix_pkg::panel_out_t panel
);

    // shifting only while the panel is dark
    clk_oe_apart: assert property (@(posedge clk_root) disable iff (!rst_n)
        !(panel.clk_pixel && panel.output_enable))
        else $error("clk_pixel high while output_enable is on");

    latch_oe_apart: assert property (@(posedge clk_root) disable iff (!rst_n)
        !(panel.row_latch && panel.output_enable))
        else $error("row_latch high while output_enable is on");

    // single cycle latch pulse
    latch_one_cycle: assert property (@(posedge clk_root) disable iff (!rst_n)
        panel.row_latch |=> !panel.row_latch)
        else $error("row_latch held for more than one cycle");

endmodule

/* verif/tb_top.sv */
// ====================
// led matrix driver testbench
// uart stimulus, reference model and scan compare
// ====================
module tb_top;

    import matrix_pkg::*;
    import ctrl_pkg::*;

    localparam int TICKS_PER_BIT = 8;
    localparam int BASE_TICKS    = 4;
    localparam int CLK_PERIOD    = 10;
    localparam int DRIVE_DLY     = 1;
    localparam int IDLE_BITS     = 2;   // line rest after each stop bit
    localparam int BYTE_CYCLES   = (10 + IDLE_BITS) * TICKS_PER_BIT;
    localparam int FRAME_PLANES  = NUM_ROW_ADDR * COLOR_DEPTH;
    localparam int NUM_PHASES    = 5;
    // 128 pixel writes of 3 bytes, then 11 mask and opcode bytes
    localparam int NUM_BYTES     = 2 * NUM_ROW_ADDR * NUM_COLS * 3 + 11;
    localparam logic [31:0] SEED = 32'he308c0af;

    logic       clk_root;
    logic       rst_n;
    logic       serial_in;
    panel_out_t panel;

    // reference model of the store and masks
    pixel_t                 model_fb [2][NUM_ROW_ADDR][NUM_COLS];
    logic [COLOR_DEPTH-1:0] model_bright;
    rgb_bits_t              model_rgb;
    logic [31:0]            rng_state;

    string     test_name;
    logic      check_en;
    logic      row_clean;   // whole shift seen with checking on
    int        rows_checked;
    int        shift_cnt;
    int        exp_row;
    int        exp_plane;
    int        lit_plane;
    int        oe_cnt;
    logic      clk_pixel_q;
    logic      row_latch_q;
    logic      oe_q;
    rgb_bits_t shifted_top [NUM_COLS];
    rgb_bits_t shifted_bot [NUM_COLS];
    event      latch_ev;

    clk_rst_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) clk_rst_gen_i (
        .clk_root (clk_root),
        .rst_n    (rst_n)
    );

    led_matrix_top #(
        .TICKS_PER_BIT (TICKS_PER_BIT),
        .BASE_TICKS    (BASE_TICKS)
    ) dut_i (
        .clk_root  (clk_root),
        .rst_n     (rst_n),
        .serial_in (serial_in),
        .panel     (panel)
    );

    bind scan_fsm scan_checker scan_checker_i (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .panel    (panel)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // upper bound on clocks for all rows and planes
    function automatic int frame_cycles();
        int total;
        total = 0;
        for (int p = 0; p < COLOR_DEPTH; p++) begin
            total += 2 * NUM_COLS + 4 + (BASE_TICKS << p);
        end
        return total * NUM_ROW_ADDR;
    endfunction

    function automatic rgb_bits_t expected_bits(input logic half, input row_addr_t row,
                                                input col_addr_t col, input plane_t pl);
        pixel_t    pix;
        rgb_bits_t bits;
        pix        = model_fb[half][row][col];
        bits.red   = pix.red[pl] && model_rgb.red;
        bits.green = pix.green[pl] && model_rgb.green;
        bits.blue  = pix.blue[pl] && model_rgb.blue;
        if (!model_bright[pl]) begin
            bits = '0;   // plane switched off
        end
        return bits;
    endfunction

    task automatic flag_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("ERR %s: %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
        $display("Test failures found");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic drive_bit(input logic value);
        @(posedge clk_root);
        #DRIVE_DLY;
        serial_in = value;
        repeat (TICKS_PER_BIT - 1) @(posedge clk_root);
    endtask

    task automatic send_byte(input logic [7:0] data);
        logic [7:0] bits;
        bits = data;
        drive_bit(1'b0);   // start
        for (int i = 0; i < 8; i++) begin
            drive_bit(bits[0]);
            bits = bits >> 1;
        end
        drive_bit(1'b1);
        repeat (IDLE_BITS) drive_bit(1'b1);
    endtask

    task automatic write_pixel(input logic half, input row_addr_t row, input col_addr_t col,
                               input pixel_t pix);
        send_byte(WRITE_PIXEL);
        send_byte({1'b0, half, row, col});
        send_byte({2'b00, pix});
        model_fb[half][row][col] = pix;
    endtask

    task automatic compare_row(input row_addr_t row, input plane_t pl);
        rgb_bits_t exp_bits;
        assert (shift_cnt == NUM_COLS)
            else flag_mismatch("shifted column count", NUM_COLS, shift_cnt);
        for (int col = 0; col < NUM_COLS; col++) begin
            exp_bits = expected_bits(1'b0, row, col_addr_t'(col), pl);
            assert (shifted_top[col_addr_t'(col)] == exp_bits)
                else flag_mismatch($sformatf("top row %0d col %0d plane %0d", row, col, pl),
                                   32'(exp_bits), 32'(shifted_top[col_addr_t'(col)]));
            exp_bits = expected_bits(1'b1, row, col_addr_t'(col), pl);
            assert (shifted_bot[col_addr_t'(col)] == exp_bits)
                else flag_mismatch($sformatf("bottom row %0d col %0d plane %0d", row, col, pl),
                                   32'(exp_bits), 32'(shifted_bot[col_addr_t'(col)]));
        end
    endtask

    // one full frame compared, starting on a row boundary
    task automatic check_frame();
        @(latch_ev);
        rows_checked = 0;
        check_en     = 1'b1;
        wait (rows_checked >= FRAME_PLANES);
        check_en = 1'b0;
    endtask

    // compare process, sampled mid-cycle
    always @(negedge clk_root) begin
        if (rst_n) begin
            if (panel.clk_pixel && !clk_pixel_q) begin
                if (shift_cnt < NUM_COLS) begin
                    shifted_top[col_addr_t'(shift_cnt)] = panel.rgb_top;
                    shifted_bot[col_addr_t'(shift_cnt)] = panel.rgb_bottom;
                end
                shift_cnt++;
            end
            if (panel.row_latch && !row_latch_q) begin
                assert (panel.row_addr == row_addr_t'(exp_row))
                    else flag_mismatch("row_addr at latch", exp_row, 32'(panel.row_addr));
                if (check_en && row_clean) begin
                    compare_row(row_addr_t'(exp_row), plane_t'(exp_plane));
                    rows_checked++;
                end
                lit_plane = exp_plane;
                if (exp_plane == COLOR_DEPTH - 1) begin
                    exp_plane = 0;
                    exp_row   = (exp_row + 1) % NUM_ROW_ADDR;
                end else begin
                    exp_plane++;
                end
                shift_cnt = 0;
                row_clean = 1'b1;
                -> latch_ev;
            end else if (!check_en) begin
                row_clean = 1'b0;
            end
            if (panel.output_enable) begin
                oe_cnt++;
            end else if (oe_q) begin
                assert (oe_cnt == (BASE_TICKS << lit_plane))
                    else flag_mismatch("output_enable cycles", BASE_TICKS << lit_plane, oe_cnt);
                oe_cnt = 0;
            end
            clk_pixel_q = panel.clk_pixel;
            row_latch_q = panel.row_latch;
            oe_q        = panel.output_enable;
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (NUM_BYTES * BYTE_CYCLES + NUM_PHASES * 4 * frame_cycles() + 20));
        $display("timeout: the uart traffic or the panel scan did not finish in time");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin : main_flow
        logic [7:0] pix_byte;
        serial_in    = 1'b1;   // uart idle
        check_en     = 1'b0;
        row_clean    = 1'b0;
        rows_checked = 0;
        shift_cnt    = 0;
        exp_row      = 0;
        exp_plane    = 0;
        lit_plane    = 0;
        oe_cnt       = 0;
        clk_pixel_q  = 1'b0;
        row_latch_q  = 1'b0;
        oe_q         = 1'b0;
        model_bright = '1;
        model_rgb    = '1;
        rng_state    = SEED;
        for (int h = 0; h < 2; h++) begin
            for (int r = 0; r < NUM_ROW_ADDR; r++) begin
                for (int c = 0; c < NUM_COLS; c++) begin
                    model_fb[h][r][c] = '0;
                end
            end
        end

        test_name = "reset state";
        @(posedge rst_n);
        @(negedge clk_root);
        assert (!panel.clk_pixel && !panel.row_latch && !panel.output_enable
                && panel.row_addr == '0)
            else flag_mismatch("panel controls after reset", 32'h0,
                               32'({panel.row_addr, panel.clk_pixel, panel.row_latch,
                                    panel.output_enable}));
        check_frame();

        test_name = "random pixels";
        for (int h = 0; h < 2; h++) begin
            for (int r = 0; r < NUM_ROW_ADDR; r++) begin
                for (int c = 0; c < NUM_COLS; c++) begin
                    rng_state = xorshift32(rng_state);
                    write_pixel(h[0], row_addr_t'(r), col_addr_t'(c), pixel_t'(rng_state[5:0]));
                end
            end
        end
        check_frame();

        test_name = "red channel only";
        send_byte(SET_RGB);
        send_byte(8'h04);
        model_rgb = 3'b100;
        check_frame();

        test_name = "plane 1 only";
        send_byte(SET_RGB);
        send_byte(8'h07);
        send_byte(SET_BRIGHTNESS);
        send_byte(8'h02);
        model_rgb    = '1;
        model_bright = 2'b10;
        check_frame();

        // unknown opcode, then what would be a write to bottom row 2 col 7
        test_name = "unknown opcode";
        send_byte(SET_BRIGHTNESS);
        send_byte(8'h03);
        model_bright = '1;
        pix_byte = {2'b00, model_fb[1][2][7] ^ 6'h3f};
        if (pix_byte < 8'h04) begin
            pix_byte = pix_byte | 8'h30;   // keep it off the opcode values
        end
        send_byte(8'h55);
        send_byte(8'h67);
        send_byte(pix_byte);
        check_frame();

        $display("All tests passed!");
        $finish;
    end

endmodule
